//--- hdl/vstream_consts.svh
`ifndef VSTREAM_CONSTS_SVH
`define VSTREAM_CONSTS_SVH

// number of processing columns, at least 2
`define VS_NUM_COL 4

// width of one register-file word
`define VS_DATA_W 16

// words held in each column register file
`define VS_DEPTH 8

`endif

//--- hdl/vstream_pkg.sv
`default_nettype none

`include "vstream_consts.svh"

package vstream_pkg;

    // derived widths
    localparam int col_w = (`VS_NUM_COL > 1) ? $clog2(`VS_NUM_COL) : 1;
    localparam int addr_w = (`VS_DEPTH > 1) ? $clog2(`VS_DEPTH) : 1;
    // one extra bit so that a full-depth length fits
    localparam int vlen_w = addr_w + 1;

    typedef logic [col_w-1:0] col_idx_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [vlen_w-1:0] vlen_t;

    // shared register-file write port
    typedef struct packed {
        logic                  en;
        col_idx_t              col;
        addr_t                 addr;
        logic [`VS_DATA_W-1:0] data;
    } wr_req_t;

    // one word on the output stream
    typedef struct packed {
        logic [`VS_DATA_W-1:0] data;
        col_idx_t              col;
        // final word of the instruction
        logic                  last;
    } stream_beat_t;

endpackage

`default_nettype wire

//--- hdl/column_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "vstream_consts.svh"

module column_buffer #(
    parameter int col_id = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  vstream_pkg::wr_req_t  wr,
    input  logic                  start,
    input  vstream_pkg::vlen_t    vl,
    input  logic                  active,
    input  logic                  grant,
    output logic                  pending,
    output logic                  done,
    output logic [`VS_DATA_W-1:0] rd_data
);

    // local register file
    logic [`VS_DATA_W-1:0] mem [`VS_DEPTH];

    vstream_pkg::addr_t rd_cnt;
    vstream_pkg::vlen_t vl_q;
    logic               wr_hit;
    logic               accept;
    logic               reading;
    logic               at_last_word;

    // the write port is shared by all columns, match on our index
    assign wr_hit = wr.en && (wr.col == vstream_pkg::col_idx_t'(col_id));

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // start only counts while the controller is idle and we are not already armed
    assign accept = start && !active && !pending;

    // vector length of the armed instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            vl_q <= vl;
        end
    end

    // this column owns the stream while granted
    assign reading = active && grant;

    assign at_last_word =
        (vstream_pkg::vlen_t'(rd_cnt) + vstream_pkg::vlen_t'(1)) == vl_q;

    assign done = reading && at_last_word;

    // word under the read counter, selected downstream by the output mux
    assign rd_data = mem[rd_cnt];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            rd_cnt  <= '0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end

            // rewind after the last word so the next instruction starts at 0
            if (done) begin
                rd_cnt <= '0;
            end else if (reading) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/vstreamout_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "vstream_consts.svh"

module vstreamout_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`VS_NUM_COL-1:0] is_vstreamout,
    input  logic [`VS_NUM_COL-1:0] done,
    output logic [`VS_NUM_COL-1:0] supplier,
    output logic [`VS_NUM_COL-1:0] mux_control,
    output logic                   clken_pc,
    output logic                   is_vstreamout_global
);

    localparam logic [`VS_NUM_COL-1:0] first_col = {{(`VS_NUM_COL-1){1'b0}}, 1'b1};

    typedef enum logic {
        st_idle,
        st_active
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    logic [`VS_NUM_COL-1:0] supplier_nxt;
    logic [`VS_NUM_COL-1:0] mux_control_nxt;
    logic                   all_pending;
    logic                   mid_done;
    logic                   last_done;

    // every column must have accepted the instruction before draining
    assign all_pending = &is_vstreamout;

    // granted column finished, and it is not the final one
    assign mid_done  = |(supplier[`VS_NUM_COL-2:0] & done[`VS_NUM_COL-2:0]);
    assign last_done = supplier[`VS_NUM_COL-1] & done[`VS_NUM_COL-1];

    assign is_vstreamout_global = (state == st_active);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            supplier    <= first_col;
            mux_control <= '0;
        end else begin
            state       <= state_nxt;
            supplier    <= supplier_nxt;
            mux_control <= mux_control_nxt;
        end
    end

    always_comb begin
        case (state)
            st_active: begin
                if (mid_done) begin
                    // hand the stream to the next column
                    state_nxt       = st_active;
                    supplier_nxt    = supplier << 1;
                    mux_control_nxt = mux_control << 1;
                    clken_pc        = 1'b0;
                end else if (last_done) begin
                    // whole vector drained, let the PC move on
                    state_nxt       = st_idle;
                    supplier_nxt    = first_col;
                    mux_control_nxt = '0;
                    clken_pc        = 1'b1;
                end else begin
                    state_nxt       = st_active;
                    supplier_nxt    = supplier;
                    mux_control_nxt = mux_control;
                    clken_pc        = 1'b0;
                end
            end
            default: begin
                if (all_pending) begin
                    state_nxt       = st_active;
                    supplier_nxt    = first_col;
                    mux_control_nxt = first_col;
                    clken_pc        = 1'b0;
                end else begin
                    state_nxt       = st_idle;
                    supplier_nxt    = first_col;
                    mux_control_nxt = '0;
                    clken_pc        = 1'b0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/stream_out_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "vstream_consts.svh"

module stream_out_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                active,
    input  logic [`VS_NUM_COL-1:0]              mux_control,
    input  logic                                last_done,
    input  logic [`VS_NUM_COL*`VS_DATA_W-1:0]   col_data,
    output logic                                out_valid,
    output vstream_pkg::stream_beat_t           out_beat
);

    vstream_pkg::stream_beat_t beat_nxt;
    logic [`VS_DATA_W-1:0]     sel_data;
    vstream_pkg::col_idx_t     sel_col;

    // one-hot select as an OR of the masked words and indices
    always_comb begin
        sel_data = '0;
        sel_col  = '0;
        for (int i = 0; i < `VS_NUM_COL; i++) begin
            if (mux_control[i]) begin
                sel_data = sel_data | col_data[i*`VS_DATA_W +: `VS_DATA_W];
                sel_col  = sel_col | vstream_pkg::col_idx_t'(i);
            end
        end
    end

    always_comb begin
        beat_nxt.data = sel_data;
        beat_nxt.col  = sel_col;
        // last column's done marks the final word of the instruction
        beat_nxt.last = last_done;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= active && (|mux_control);
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        out_beat <= beat_nxt;
    end

endmodule

`default_nettype wire

//--- hdl/vstream_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "vstream_consts.svh"

module vstream_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  vstream_pkg::wr_req_t      wr,
    input  logic                      start,
    input  vstream_pkg::vlen_t        vl,
    output logic                      out_valid,
    output vstream_pkg::stream_beat_t out_beat,
    output logic                      instr_done,
    output logic                      busy
);

    logic [`VS_NUM_COL-1:0]            pending;
    logic [`VS_NUM_COL-1:0]            col_done;
    logic [`VS_NUM_COL-1:0]            supplier;
    logic [`VS_NUM_COL-1:0]            mux_control;
    logic [`VS_NUM_COL*`VS_DATA_W-1:0] col_data;
    logic                              active;

    // one register file per column, drained in index order
    for (genvar c = 0; c < `VS_NUM_COL; c++) begin : g_col
        column_buffer #(
            .col_id (c)
        ) u_col (
            .clk     (clk),
            .rst     (rst),
            .wr      (wr),
            .start   (start),
            .vl      (vl),
            .active  (active),
            .grant   (supplier[c]),
            .pending (pending[c]),
            .done    (col_done[c]),
            .rd_data (col_data[c*`VS_DATA_W +: `VS_DATA_W])
        );
    end

    vstreamout_control u_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .is_vstreamout        (pending),
        .done                 (col_done),
        .supplier             (supplier),
        .mux_control          (mux_control),
        .clken_pc             (instr_done),
        .is_vstreamout_global (active)
    );

    // final beat is flagged by the last column's done
    stream_out_stage u_out (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .mux_control (mux_control),
        .last_done   (col_done[`VS_NUM_COL-1]),
        .col_data    (col_data),
        .out_valid   (out_valid),
        .out_beat    (out_beat)
    );

    assign busy = active;

endmodule

`default_nettype wire

//--- verification/vstream_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "vstream_consts.svh"

module vstream_tb;

    localparam int num_col = `VS_NUM_COL;
    localparam int depth = `VS_DEPTH;
    localparam int num_instr = 40;
    localparam int max_writes = 6;
    // per instruction the beats, the writes and the start and drain overhead
    localparam int timeout_cycles =
        num_instr * (num_col * depth + max_writes + 8) + num_col * depth + 8 + 1000;

    logic                      clk;
    logic                      rst;
    vstream_pkg::wr_req_t      wr;
    logic                      start;
    vstream_pkg::vlen_t        vl;
    logic                      out_valid;
    vstream_pkg::stream_beat_t out_beat;
    logic                      instr_done;
    logic                      busy;

    int seed;
    int errors;
    int checks;
    int cycles;
    int done_cnt;
    int stray_cnt;

    logic started;
    logic in_burst;
    logic prev_done;

    // mirror of every column register file
    logic [`VS_DATA_W-1:0] model [num_col][depth];

    vstream_pkg::stream_beat_t exp_q[$];
    vstream_pkg::stream_beat_t mon_beat;

    vstream_unit dut0 (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .start      (start),
        .vl         (vl),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .instr_done (instr_done),
        .busy       (busy)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // called on a falling edge and returns on the next one
    task automatic write_word(input int col, input int addr, input logic [`VS_DATA_W-1:0] data);
        wr.en   = 1'b1;
        wr.col  = vstream_pkg::col_idx_t'(col);
        wr.addr = vstream_pkg::addr_t'(addr);
        wr.data = data;
        model[col][addr] = data;
        @(negedge clk);
        wr.en = 1'b0;
    endtask

    task automatic load_all();
        for (int c = 0; c < num_col; c++) begin
            for (int a = 0; a < depth; a++) begin
                write_word(c, a, `VS_DATA_W'($random(seed)));
            end
        end
    endtask

    // strobe start and queue the beats the model predicts
    task automatic start_instr(input int len);
        vstream_pkg::stream_beat_t beat;
        start   = 1'b1;
        vl      = vstream_pkg::vlen_t'(len);
        started = 1'b1;
        // column-major order with ascending addresses
        for (int c = 0; c < num_col; c++) begin
            for (int a = 0; a < len; a++) begin
                beat.data = model[c][a];
                beat.col  = vstream_pkg::col_idx_t'(c);
                beat.last = (c == num_col - 1) && (a == len - 1);
                exp_q.push_back(beat);
            end
        end
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_instr(input int idx);
        int   len;
        int   n_wr;
        int   delay;
        logic stray;
        n_wr = rand_below(max_writes + 1);
        for (int j = 0; j < n_wr; j++) begin
            write_word(rand_below(num_col), rand_below(depth), `VS_DATA_W'($random(seed)));
        end
        if (idx == 0) begin
            len = depth;
        end else if (idx == 1) begin
            len = 1;
        end else begin
            len = rand_below(depth) + 1;
        end
        start_instr(len);
        while (!busy) begin
            @(negedge clk);
        end
        stray = (idx == 2) || (rand_below(3) == 0);
        if (stray) begin
            // stays inside column 0's slot so busy is still high
            delay = rand_below(len);
            repeat (delay) @(negedge clk);
            if (busy) begin
                start = 1'b1;
                vl    = vstream_pkg::vlen_t'(rand_below(depth) + 1);
                stray_cnt++;
                @(negedge clk);
                start = 1'b0;
            end
        end
        while (busy) begin
            @(negedge clk);
        end
        // final beat is sampled by the monitor on this edge
        @(negedge clk);
        check_value("beats left after instruction", 32'd0, 32'(exp_q.size()));
        check_value("instr_done count", 32'(idx + 1), 32'(done_cnt));
    endtask

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            if (!started && (out_valid || instr_done || busy)) begin
                errors++;
                $display("output stream or busy active before the first start");
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("beat on the output stream with none expected");
                end else begin
                    mon_beat = exp_q.pop_front();
                    check_value("beat data", 32'(mon_beat.data), 32'(out_beat.data));
                    check_value("beat column", 32'(mon_beat.col), 32'(out_beat.col));
                    check_value("beat last", 32'(mon_beat.last), 32'(out_beat.last));
                    // instr_done leads only the final beat by one cycle
                    check_value("instr_done before last beat", 32'(mon_beat.last),
                                32'(prev_done));
                    // busy drops together with the final beat
                    check_value("busy during beat", 32'(!mon_beat.last), 32'(busy));
                end
            end
            if (in_burst && !out_valid) begin
                errors++;
                $display("gap in the beat stream before the last beat");
            end
            in_burst = out_valid && !out_beat.last;
            if (instr_done) begin
                done_cnt++;
                check_value("beats left at instr_done", 32'd1, 32'(exp_q.size()));
            end
            prev_done = instr_done;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, stream-out did not complete", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed      = 32'h5506;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        done_cnt  = 0;
        stray_cnt = 0;
        started   = 1'b0;
        in_burst  = 1'b0;
        prev_done = 1'b0;
        clk       = 1'b0;
        rst       = 1'b1;
        wr        = '0;
        start     = 1'b0;
        vl        = '0;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        // idle outputs are watched by the monitor until the first start
        repeat (4) @(negedge clk);
        load_all();

        for (int i = 0; i < num_instr; i++) begin
            run_instr(i);
        end

        // a stray start that slipped in would show up here
        repeat (num_col * depth + 4) @(negedge clk);
        check_value("total instr_done pulses", 32'(num_instr), 32'(done_cnt));
        check_value("beats never delivered", 32'd0, 32'(exp_q.size()));
        if (stray_cnt == 0) begin
            errors++;
            $display("no start was issued while busy");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/vstream_pkg.sv
hdl/column_buffer.sv
hdl/vstreamout_control.sv
hdl/stream_out_stage.sv
hdl/vstream_unit.sv
verification/vstream_tb.sv

//--- Makefile
TOP := vstream_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

# fails unless the testbench prints the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)
	verilator --lint-only -Wall -f all.f --top-module vstream_unit

clean:
	rm -rf obj_dir
